// ==== exec_pkg.sv ====
// **************************************************
// Shared types of the integer execute cluster
// Word type, ALU / branch / shift operation enums
// and the state of a unit's result holding register
// **************************************************
`default_nettype none

package exec_pkg;

	// Operand and result word
	typedef logic [31:0] word_t;

	// ALU operations
	// Every op that needs the subtract datapath has bit 2 set,
	// the adder takes that bit as invert / carry-in control
	typedef enum logic [3:0] {
		ADD  = 4'b0000,
		XOR  = 4'b0001,
		OR   = 4'b0010,
		AND  = 4'b0011,
		SUB  = 4'b0100,
		SLT  = 4'b0101, // Signed less than
		SLTU = 4'b0110  // Unsigned less than
	} alu_op_t;

	// Branch compare types, resolved on the SUB datapath
	typedef enum logic [2:0] {
		NONE = 3'd0,
		BEQ  = 3'd1,
		BNE  = 3'd2,
		BLT  = 3'd3,
		BGE  = 3'd4,
		BLTU = 3'd5,
		BGEU = 3'd6
	} branch_t;

	// Shift operations
	typedef enum logic [1:0] {
		SLL = 2'd0,
		SRL = 2'd1,
		SRA = 2'd2 // Sign fill
	} shift_op_t;

	// Holding register of a functional unit
	typedef enum logic {
		EMPTY = 1'b0, // Ready for issue
		HOLD  = 1'b1  // Result waiting for the CDB
	} unit_state_t;

endpackage

`default_nettype wire

// ==== fu_result_if.sv ====
// **************************************************
// Held result of one functional unit and the
// acknowledge (yumi) back from the CDB arbiter
// **************************************************
`timescale 1ns/1ps
`default_nettype none

interface fu_result_if #(
	parameter int ROB_W = 4
);

	logic               valid;        // Unit holds a result
	exec_pkg::word_t    result;
	logic [ROB_W-1:0]   rob;          // Destination ROB entry
	logic               branch_taken;
	logic               load_step1;   // From issue, first step of a load
	logic               yumi;         // Only high while valid

	modport unit (
		output valid, result, rob, branch_taken, load_step1,
		input  yumi
	);

	modport arb (
		input  valid, result, rob, branch_taken, load_step1,
		output yumi
	);

endinterface

`default_nettype wire

// ==== alu_unit.sv ====
// **************************************************
// Add / subtract / compare / logic unit
// Branch resolution on the subtract flags and a
// one-entry result holding register
// **************************************************
`timescale 1ns/1ps
`default_nettype none

module alu_unit #(
	parameter int ROB_W = 4
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               issue,
	input  exec_pkg::alu_op_t  op,
	input  exec_pkg::branch_t  branch,
	input  logic [ROB_W-1:0]   rob,
	input  logic               load,
	input  exec_pkg::word_t    rs1,
	input  exec_pkg::word_t    rs2,
	output logic               ready,
	fu_result_if.unit          res
);

	exec_pkg::unit_state_t state_q;

	logic             sub;
	exec_pkg::word_t  b_opnd;
	logic [32:0]      sum_ext;
	exec_pkg::word_t  sum;
	logic             zero, negative, overflow, carry;
	logic             taken;
	exec_pkg::word_t  result;

	// Held packet
	exec_pkg::word_t  result_q;
	logic [ROB_W-1:0] rob_q;
	logic             taken_q;
	logic             load_q;

	assign sub = op[2]; // Subtract for SUB, SLT, SLTU and all branches

	// Two's complement subtract as rs1 + ~rs2 + 1
	assign b_opnd  = sub ? ~rs2 : rs2;
	assign sum_ext = {1'b0, rs1} + {1'b0, b_opnd} + {32'd0, sub};
	assign sum     = sum_ext[31:0];

	assign carry    = sum_ext[32]; // No borrow, rs1 >= rs2 unsigned
	assign zero     = (sum == '0);
	assign negative = sum[31];
	assign overflow = (rs1[31] == b_opnd[31]) && (sum[31] != rs1[31]);

	always_comb begin
		case (branch)
			exec_pkg::BEQ:  taken = zero;
			exec_pkg::BNE:  taken = ~zero;
			exec_pkg::BLT:  taken = negative ^ overflow;
			exec_pkg::BGE:  taken = ~(negative ^ overflow);
			exec_pkg::BLTU: taken = ~carry;
			exec_pkg::BGEU: taken = carry;
			default:        taken = 1'b0; // Not a branch
		endcase
	end

	always_comb begin
		case (op)
			exec_pkg::SLT:  result = {31'd0, negative ^ overflow};
			exec_pkg::SLTU: result = {31'd0, ~carry};
			exec_pkg::XOR:  result = rs1 ^ rs2;
			exec_pkg::OR:   result = rs1 | rs2;
			exec_pkg::AND:  result = rs1 & rs2;
			default:        result = sum; // ADD, SUB
		endcase
	end

	// EMPTY until issue, HOLD until the arbiter takes the result
	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= exec_pkg::EMPTY;
		end else begin
			case (state_q)
				exec_pkg::EMPTY: if (issue) state_q <= exec_pkg::HOLD;
				exec_pkg::HOLD:  if (res.yumi) state_q <= exec_pkg::EMPTY;
				default:         state_q <= exec_pkg::EMPTY;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (issue && ready) begin
			result_q <= result;
			rob_q    <= rob;
			taken_q  <= taken;
			load_q   <= load;
		end
	end

	assign ready            = (state_q == exec_pkg::EMPTY);
	assign res.valid        = (state_q == exec_pkg::HOLD);
	assign res.result       = result_q;
	assign res.rob          = rob_q;
	assign res.branch_taken = taken_q;
	assign res.load_step1   = load_q;

	// Issue side must wait for ready
	a_no_issue_in_hold: assert property (
		@(posedge clk) disable iff (rst)
		issue |-> state_q == exec_pkg::EMPTY
	) else $error("alu_unit issued while holding a result");

	a_branch_is_sub: assert property (
		@(posedge clk) disable iff (rst)
		(issue && branch != exec_pkg::NONE) |-> op == exec_pkg::SUB
	) else $error("alu_unit branch issued without SUB");

endmodule

`default_nettype wire

// ==== shift_unit.sv ====
// **************************************************
// Barrel shift unit, SLL / SRL / SRA, with a
// one-entry result holding register
// **************************************************
`timescale 1ns/1ps
`default_nettype none

module shift_unit #(
	parameter int ROB_W = 4
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                issue,
	input  exec_pkg::shift_op_t op,
	input  logic [ROB_W-1:0]    rob,
	input  exec_pkg::word_t     a,
	input  logic [4:0]          amt,
	output logic                ready,
	fu_result_if.unit           res
);

	exec_pkg::unit_state_t state_q;
	exec_pkg::word_t       shifted;
	exec_pkg::word_t       result_q;
	logic [ROB_W-1:0]      rob_q;

	always_comb begin
		case (op)
			exec_pkg::SLL: shifted = a << amt;
			exec_pkg::SRL: shifted = a >> amt;
			exec_pkg::SRA: shifted = $signed(a) >>> amt; // Copies bit 31 in
			default:       shifted = a;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= exec_pkg::EMPTY;
		end else begin
			case (state_q)
				exec_pkg::EMPTY: if (issue) state_q <= exec_pkg::HOLD;
				exec_pkg::HOLD:  if (res.yumi) state_q <= exec_pkg::EMPTY;
				default:         state_q <= exec_pkg::EMPTY;
			endcase
		end
	end

	// Packet captured on issue, kept until yumi
	always_ff @(posedge clk) begin
		if (issue && ready) begin
			result_q <= shifted;
			rob_q    <= rob;
		end
	end

	assign ready      = (state_q == exec_pkg::EMPTY);
	assign res.valid  = (state_q == exec_pkg::HOLD);
	assign res.result = result_q;
	assign res.rob    = rob_q;

	// Shifts never branch and never start a load
	assign res.branch_taken = 1'b0;
	assign res.load_step1   = 1'b0;

	a_no_issue_in_hold: assert property (
		@(posedge clk) disable iff (rst)
		issue |-> state_q == exec_pkg::EMPTY
	) else $error("shift_unit issued while holding a result");

endmodule

`default_nettype wire

// ==== cdb_arbiter.sv ====
// **************************************************
// Alternating-priority CDB arbiter for the ALU and
// shift results, yumi back to the winning unit
// **************************************************
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter #(
	parameter int ROB_W = 4
) (
	input  logic             clk,
	input  logic             rst,
	fu_result_if.arb         alu,
	fu_result_if.arb         shf,
	output logic             cdb_valid,
	output exec_pkg::word_t  cdb_result,
	output logic [ROB_W-1:0] cdb_rob,
	output logic             cdb_branch_taken,
	output logic             cdb_load_step1
);

	logic prio_shf_q; // Shift unit goes first on a tie
	logic grant_alu;
	logic grant_shf;

	// ALU wins when alone or when it lost the last grant
	assign grant_alu = alu.valid && (!shf.valid || !prio_shf_q);
	assign grant_shf = shf.valid && !grant_alu;

	always_ff @(posedge clk) begin
		if (rst) begin
			prio_shf_q <= 1'b0; // ALU favored out of reset
		end else if (grant_alu) begin
			prio_shf_q <= 1'b1;
		end else if (grant_shf) begin
			prio_shf_q <= 1'b0;
		end
	end

	assign alu.yumi = grant_alu;
	assign shf.yumi = grant_shf;

	// The CDB is always taken, so valid is just "anyone holds a result"
	assign cdb_valid        = alu.valid | shf.valid;
	assign cdb_result       = grant_shf ? shf.result       : alu.result;
	assign cdb_rob          = grant_shf ? shf.rob          : alu.rob;
	assign cdb_branch_taken = grant_shf ? shf.branch_taken : alu.branch_taken;
	assign cdb_load_step1   = grant_shf ? shf.load_step1   : alu.load_step1;

	a_one_yumi: assert property (
		@(posedge clk) disable iff (rst)
		!(alu.yumi && shf.yumi)
	) else $error("Both units acknowledged in one cycle");

	a_yumi_with_valid: assert property (
		@(posedge clk) disable iff (rst)
		(alu.yumi |-> alu.valid) and (shf.yumi |-> shf.valid)
	) else $error("yumi raised without a held result");

	// A loser on a tie is served in the very next cycle
	a_loser_next: assert property (
		@(posedge clk) disable iff (rst)
		(alu.valid && shf.valid && grant_alu) |=> grant_shf
	) else $error("Shift result not served after losing a tie");

endmodule

`default_nettype wire

// ==== exec_cluster.sv ====
// **************************************************
// Integer execute cluster top level
// ALU and shift units sharing one CDB via the arbiter
// **************************************************
`timescale 1ns/1ps
`default_nettype none

module exec_cluster #(
	parameter int ROB_W = 4
) (
	input  logic                clk,
	input  logic                rst,

	// ALU issue
	input  logic                alu_issue,
	input  exec_pkg::alu_op_t   alu_op,
	input  exec_pkg::branch_t   alu_branch,
	input  logic [ROB_W-1:0]    alu_rob,
	input  logic                alu_load,
	input  exec_pkg::word_t     alu_rs1,
	input  exec_pkg::word_t     alu_rs2,
	output logic                alu_ready,

	// Shift issue
	input  logic                shift_issue,
	input  exec_pkg::shift_op_t shift_op,
	input  logic [ROB_W-1:0]    shift_rob,
	input  exec_pkg::word_t     shift_a,
	input  logic [4:0]          shift_amt,
	output logic                shift_ready,

	// Common data bus
	output logic                cdb_valid,
	output exec_pkg::word_t     cdb_result,
	output logic [ROB_W-1:0]    cdb_rob,
	output logic                cdb_branch_taken,
	output logic                cdb_load_step1
);

	fu_result_if #(.ROB_W(ROB_W)) alu_res_if ();
	fu_result_if #(.ROB_W(ROB_W)) shf_res_if ();

	alu_unit #(.ROB_W(ROB_W)) alu_unit_i (
		.clk    (clk),
		.rst    (rst),
		.issue  (alu_issue),
		.op     (alu_op),
		.branch (alu_branch),
		.rob    (alu_rob),
		.load   (alu_load),
		.rs1    (alu_rs1),
		.rs2    (alu_rs2),
		.ready  (alu_ready),
		.res    (alu_res_if.unit)
	);

	shift_unit #(.ROB_W(ROB_W)) shift_unit_i (
		.clk   (clk),
		.rst   (rst),
		.issue (shift_issue),
		.op    (shift_op),
		.rob   (shift_rob),
		.a     (shift_a),
		.amt   (shift_amt),
		.ready (shift_ready),
		.res   (shf_res_if.unit)
	);

	cdb_arbiter #(.ROB_W(ROB_W)) cdb_arbiter_i (
		.clk              (clk),
		.rst              (rst),
		.alu              (alu_res_if.arb),
		.shf              (shf_res_if.arb),
		.cdb_valid        (cdb_valid),
		.cdb_result       (cdb_result),
		.cdb_rob          (cdb_rob),
		.cdb_branch_taken (cdb_branch_taken),
		.cdb_load_step1   (cdb_load_step1)
	);

endmodule

`default_nettype wire

// ==== tb_model.svh ====
// **************************************************
// Reference model of the execute cluster, queues of
// expected CDB packets and typed compare tasks
// **************************************************
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// One expected CDB packet
typedef struct {
	bit               is_shift;
	exec_pkg::word_t  result;
	logic [ROB_W-1:0] rob;
	logic             taken;
	logic             load;
	int               issue_cyc; // Clock edge that captured the issue
} exp_pkt_t;

exp_pkt_t alu_q[$];
exp_pkt_t shf_q[$];

function automatic exec_pkg::word_t alu_expect(input exec_pkg::alu_op_t op,
		input exec_pkg::word_t rs1, input exec_pkg::word_t rs2);
	case (op)
		exec_pkg::ADD:  return rs1 + rs2; // Wraps modulo 2^32
		exec_pkg::SUB:  return rs1 - rs2;
		exec_pkg::SLT:  return ($signed(rs1) < $signed(rs2)) ? 32'd1 : 32'd0;
		exec_pkg::SLTU: return (rs1 < rs2) ? 32'd1 : 32'd0;
		exec_pkg::XOR:  return rs1 ^ rs2;
		exec_pkg::OR:   return rs1 | rs2;
		exec_pkg::AND:  return rs1 & rs2;
		default:        return '0;
	endcase
endfunction

function automatic logic branch_expect(input exec_pkg::branch_t br,
		input exec_pkg::word_t rs1, input exec_pkg::word_t rs2);
	case (br)
		exec_pkg::BEQ:  return rs1 == rs2;
		exec_pkg::BNE:  return rs1 != rs2;
		exec_pkg::BLT:  return $signed(rs1) < $signed(rs2);
		exec_pkg::BGE:  return $signed(rs1) >= $signed(rs2);
		exec_pkg::BLTU: return rs1 < rs2;
		exec_pkg::BGEU: return rs1 >= rs2;
		default:        return 1'b0; // Not a branch
	endcase
endfunction

function automatic exec_pkg::word_t shift_expect(input exec_pkg::shift_op_t op,
		input exec_pkg::word_t a, input logic [4:0] amt);
	exec_pkg::word_t fill;
	fill = a[31] ? ~(32'hffff_ffff >> amt) : 32'd0; // Sign bits shifted in
	case (op)
		exec_pkg::SLL: return a << amt;
		exec_pkg::SRL: return a >> amt;
		exec_pkg::SRA: return (a >> amt) | fill;
		default:       return a;
	endcase
endfunction

task automatic check_word(input string name, input exec_pkg::word_t got,
		input exec_pkg::word_t exp);
	if (got !== exp)
		fail_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
endtask

task automatic check_rob(input string name, input logic [ROB_W-1:0] got,
		input logic [ROB_W-1:0] exp);
	if (got !== exp)
		fail_run($sformatf("ERR %0t %s got %0d expected %0d", $time, name, got, exp));
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp)
		fail_run($sformatf("ERR %0t %s got %b expected %b", $time, name, got, exp));
endtask

`endif

// ==== tb_exec_cluster.sv ====
// **************************************************
// Testbench for the execute cluster: clock, reset,
// LFSR stimulus, issue control, CDB checks, timeout
// **************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_exec_cluster;

	localparam int ROB_W          = 4;
	localparam int N_ISSUE        = 600;
	localparam int TIMEOUT_CYCLES = N_ISSUE * 3 + 100;

	logic                clk;
	logic                rst;
	logic                alu_issue;
	exec_pkg::alu_op_t   alu_op;
	exec_pkg::branch_t   alu_branch;
	logic [ROB_W-1:0]    alu_rob;
	logic                alu_load;
	exec_pkg::word_t     alu_rs1;
	exec_pkg::word_t     alu_rs2;
	logic                alu_ready;
	logic                shift_issue;
	exec_pkg::shift_op_t shift_op;
	logic [ROB_W-1:0]    shift_rob;
	exec_pkg::word_t     shift_a;
	logic [4:0]          shift_amt;
	logic                shift_ready;
	logic                cdb_valid;
	exec_pkg::word_t     cdb_result;
	logic [ROB_W-1:0]    cdb_rob;
	logic                cdb_branch_taken;
	logic                cdb_load_step1;

	logic [31:0]      lfsr;
	int               cycle_cnt;
	int               wd_cnt = 0;
	int               issued;
	int               drain;
	logic [ROB_W-2:0] alu_tag; // ALU tags in the lower half, shifts in the upper
	logic [ROB_W-2:0] shf_tag;
	bit               last_shf;

	exec_cluster #(.ROB_W(ROB_W)) exec_cluster_i (
		.clk              (clk),
		.rst              (rst),
		.alu_issue        (alu_issue),
		.alu_op           (alu_op),
		.alu_branch       (alu_branch),
		.alu_rob          (alu_rob),
		.alu_load         (alu_load),
		.alu_rs1          (alu_rs1),
		.alu_rs2          (alu_rs2),
		.alu_ready        (alu_ready),
		.shift_issue      (shift_issue),
		.shift_op         (shift_op),
		.shift_rob        (shift_rob),
		.shift_a          (shift_a),
		.shift_amt        (shift_amt),
		.shift_ready      (shift_ready),
		.cdb_valid        (cdb_valid),
		.cdb_result       (cdb_result),
		.cdb_rob          (cdb_rob),
		.cdb_branch_taken (cdb_branch_taken),
		.cdb_load_step1   (cdb_load_step1)
	);

	always #4 clk = ~clk;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	`include "tb_model.svh"

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int          i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	always @(posedge clk) begin
		wd_cnt++;
		if (wd_cnt >= TIMEOUT_CYCLES)
			fail_run($sformatf("Timeout after %0d cycles, run did not finish", wd_cnt));
	end

	// Sampled at the rising edge, before the DUT registers update
	task automatic check_cdb();
		bit       alu_pend;
		bit       shf_pend;
		bit       pick_shf;
		exp_pkt_t e;
		alu_pend = (alu_q.size() > 0) && (alu_q[0].issue_cyc < cycle_cnt);
		shf_pend = (shf_q.size() > 0) && (shf_q[0].issue_cyc < cycle_cnt);
		if (!cdb_valid) begin
			if (alu_pend || shf_pend)
				fail_run($sformatf("Held result missing from the CDB at %0t", $time));
		end else if (!alu_pend && !shf_pend) begin
			fail_run($sformatf("CDB valid at %0t with no result outstanding", $time));
		end else begin
			pick_shf = shf_pend && (!alu_pend || !last_shf); // Loser of last grant first
			// Tag ranges are disjoint, so the tag names the unit
			if (shf_pend && cdb_rob === shf_q[0].rob)
				e = shf_q.pop_front();
			else if (alu_pend && cdb_rob === alu_q[0].rob)
				e = alu_q.pop_front();
			else
				check_rob("cdb_rob", cdb_rob, pick_shf ? shf_q[0].rob : alu_q[0].rob);
			if (cycle_cnt - e.issue_cyc > 2)
				fail_run($sformatf("ROB tag %0d took %0d cycles to reach the CDB",
					e.rob, cycle_cnt - e.issue_cyc));
			check_bit("cdb shift unit granted", e.is_shift, pick_shf);
			last_shf = e.is_shift;
			check_word("cdb_result", cdb_result, e.result);
			check_bit("cdb_branch_taken", cdb_branch_taken, e.taken);
			check_bit("cdb_load_step1", cdb_load_step1, e.load);
		end
	endtask

	task automatic drive_alu();
		exp_pkt_t e;
		bit       go;
		check_bit("alu_ready", alu_ready, alu_q.size() == 0); // Empty while nothing held
		alu_issue = 1'b0;
		go = rand_bits(1) != 0;
		if (alu_ready && go && issued < N_ISSUE) begin
			if (rand_bits(2) == 0) begin
				alu_op = exec_pkg::SUB; // Branch on the subtract datapath
				case (rand_bits(3) % 6)
					0:       alu_branch = exec_pkg::BEQ;
					1:       alu_branch = exec_pkg::BNE;
					2:       alu_branch = exec_pkg::BLT;
					3:       alu_branch = exec_pkg::BGE;
					4:       alu_branch = exec_pkg::BLTU;
					default: alu_branch = exec_pkg::BGEU;
				endcase
			end else begin
				alu_branch = exec_pkg::NONE;
				case (rand_bits(3) % 7)
					0:       alu_op = exec_pkg::ADD;
					1:       alu_op = exec_pkg::SUB;
					2:       alu_op = exec_pkg::SLT;
					3:       alu_op = exec_pkg::SLTU;
					4:       alu_op = exec_pkg::XOR;
					5:       alu_op = exec_pkg::OR;
					default: alu_op = exec_pkg::AND;
				endcase
			end
			alu_rs1 = rand_bits(32);
			alu_rs2 = rand_bits(32);
			if (rand_bits(3) == 0)
				alu_rs1 = (rand_bits(1) != 0) ? 32'h8000_0000 : 32'h7fff_ffff; // Sign boundary
			if (rand_bits(2) == 0)
				alu_rs2 = alu_rs1; // Equal operands
			alu_load  = rand_bits(1) != 0;
			alu_rob   = {1'b0, alu_tag};
			alu_tag++;
			alu_issue = 1'b1;
			e.is_shift  = 1'b0;
			e.result    = alu_expect(alu_op, alu_rs1, alu_rs2);
			e.rob       = alu_rob;
			e.taken     = branch_expect(alu_branch, alu_rs1, alu_rs2);
			e.load      = alu_load;
			e.issue_cyc = cycle_cnt + 1;
			alu_q.push_back(e);
			issued++;
		end
	endtask

	task automatic drive_shift();
		exp_pkt_t e;
		bit       go;
		check_bit("shift_ready", shift_ready, shf_q.size() == 0);
		shift_issue = 1'b0;
		go = rand_bits(1) != 0;
		if (shift_ready && go && issued < N_ISSUE) begin
			case (rand_bits(2) % 3)
				0:       shift_op = exec_pkg::SLL;
				1:       shift_op = exec_pkg::SRL;
				default: shift_op = exec_pkg::SRA;
			endcase
			shift_a     = rand_bits(32);
			shift_amt   = 5'(rand_bits(5));
			if (rand_bits(2) == 0)
				shift_amt = (rand_bits(1) != 0) ? 5'd31 : 5'd0; // Amount corners
			shift_rob   = {1'b1, shf_tag};
			shf_tag++;
			shift_issue = 1'b1;
			e.is_shift  = 1'b1;
			e.result    = shift_expect(shift_op, shift_a, shift_amt);
			e.rob       = shift_rob;
			e.taken     = 1'b0;
			e.load      = 1'b0;
			e.issue_cyc = cycle_cnt + 1;
			shf_q.push_back(e);
			issued++;
		end
	endtask

	// Check at the edge, drive 1 ns later
	task automatic step_cycle();
		@(posedge clk);
		cycle_cnt++;
		check_cdb();
		#1;
		drive_alu();
		drive_shift();
	endtask

	initial begin
		clk         = 1'b0;
		rst         = 1'b1;
		alu_issue   = 1'b0;
		alu_op      = exec_pkg::ADD;
		alu_branch  = exec_pkg::NONE;
		alu_rob     = '0;
		alu_load    = 1'b0;
		alu_rs1     = '0;
		alu_rs2     = '0;
		shift_issue = 1'b0;
		shift_op    = exec_pkg::SLL;
		shift_rob   = '0;
		shift_a     = '0;
		shift_amt   = '0;
		lfsr        = 32'h79a8;
		cycle_cnt   = 0;
		issued      = 0;
		drain       = 0;
		alu_tag     = '0;
		shf_tag     = '0;
		last_shf    = 1'b1; // ALU wins the first tie
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		check_bit("alu_ready", alu_ready, 1'b1);
		check_bit("shift_ready", shift_ready, 1'b1);
		check_bit("cdb_valid", cdb_valid, 1'b0);
		while (issued < N_ISSUE)
			step_cycle();
		while ((alu_q.size() > 0 || shf_q.size() > 0) && drain < 4) begin
			step_cycle();
			drain++;
		end
		if (alu_q.size() == 0 && shf_q.size() == 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			fail_run($sformatf("%0d ALU and %0d shift results never reached the CDB",
				alu_q.size(), shf_q.size()));
		end
	end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
exec_pkg.sv
fu_result_if.sv
alu_unit.sv
shift_unit.sv
cdb_arbiter.sv
exec_cluster.sv
tb_exec_cluster.sv

// ==== run.sh ====
#!/bin/sh
# Build the execute cluster testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tb_exec_cluster \
	-f tb.f -o sim_exec_cluster || { echo "Build failed"; exit 1; }
out=$(./obj_dir/sim_exec_cluster 2>&1)
echo "$out"
echo "$out" | grep -q "^All checks passed$" && echo "PASS" || { echo "FAIL"; exit 1; }
